// File: hdl/dram_queue_consts.svh
/* Widths, block geometry, FIFO depths and control encodings
   of the DRAM output queue */
`ifndef DRAM_QUEUE_CONSTS_SVH
`define DRAM_QUEUE_CONSTS_SVH

`define DQ_DATA_WIDTH        64
`define DQ_CTRL_WIDTH        8
`define DQ_DRAM_WIDTH        144   // Upper word then lower word
`define DQ_BLOCK_WORDS       4     // Pairs per block
`define DQ_BLOCK_ADDR_WIDTH  3
`define DQ_DRAM_ADDR_WIDTH   5
`define DQ_STORE_FIFO_DEPTH  16
`define DQ_REMOVE_FIFO_DEPTH 32

`define DQ_CTRL_LAST         8'hff
`define DQ_CTRL_FILL         8'h0f

`define DQ_CTRL_BIT_INIT     0
`define DQ_CTRL_BIT_DISABLE  1

`endif

// File: hdl/dram_queue_pkg.sv
/* Vector types and FSM encodings shared by the queue modules */
`include "dram_queue_consts.svh"

package dram_queue_pkg;

   typedef logic [`DQ_DATA_WIDTH-1:0]       word_data_t;
   typedef logic [`DQ_CTRL_WIDTH-1:0]       word_ctrl_t;
   typedef logic [`DQ_DRAM_WIDTH-1:0]       dram_word_t;
   typedef logic [`DQ_BLOCK_ADDR_WIDTH-1:0] block_addr_t;
   typedef logic [`DQ_DRAM_ADDR_WIDTH-1:0]  dram_addr_t;
   typedef logic [1:0]                      queue_ctrl_t;

   // Block writer
   typedef enum logic [1:0] {
      ST_IDLE, ST_WR_REQ, ST_WRITE, ST_WR_DONE
   } store_state_t;

   // Block reader
   typedef enum logic [1:0] {
      ST_WAIT_FOR_DATA, ST_RD_REQ, ST_READ, ST_RD_DONE
   } remove_state_t;

endpackage

// File: hdl/pkt_fifo.sv
/* Synchronous show-ahead FIFO with fill count and almost-full flag */
module pkt_fifo #(
   parameter int WIDTH = 144,
   parameter int DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [WIDTH-1:0]           din,
   input  logic                       wr_en,
   input  logic                       rd_en,
   output logic [WIDTH-1:0]           dout,
   output logic                       full,
   output logic                       empty,
   output logic                       almost_full,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   assign dout        = mem[rd_ptr];          // Head word visible before the pop
   assign full        = (count == DEPTH);
   assign empty       = (count == 0);
   assign almost_full = (count >= DEPTH - 4);  // Leaves room for one block

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Callers keep to the flags
   a_fifo_bounds: assert property (@(posedge clk) disable iff (reset)
      !(wr_en && full) && !(rd_en && empty));

endmodule

// File: hdl/store_pkt_dram.sv
/* Write side of the queue: word pairing, short path to the read FIFO
   and block writes into the DRAM ring */
`include "dram_queue_consts.svh"

module store_pkt_dram (
   input  logic                        clk,
   input  logic                        reset,
   input  dram_queue_pkg::word_data_t  in_data,
   input  dram_queue_pkg::word_ctrl_t  in_ctrl,
   input  logic                        in_wr,
   output logic                        in_rdy,
   output dram_queue_pkg::block_addr_t oq_wr_addr,
   input  dram_queue_pkg::block_addr_t oq_rd_addr,
   output dram_queue_pkg::dram_word_t  fifo_din_in,
   output logic                        fifo_wr_en_in,
   input  logic                        fifo_almost_full_out,
   input  logic                        remove_pkt_idle,
   output logic                        dram_wr_req,
   output dram_queue_pkg::dram_addr_t  dram_wr_ptr,
   output logic                        dram_wr_en,
   output dram_queue_pkg::dram_word_t  dram_wr_data,
   input  logic                        dram_wr_ack,
   input  logic                        dram_wr_done,
   input  dram_queue_pkg::block_addr_t block_addr_hi,
   input  dram_queue_pkg::block_addr_t block_addr_lo,
   input  dram_queue_pkg::queue_ctrl_t ctrl
);
   import dram_queue_pkg::*;

   localparam int CNT_W = $clog2(`DQ_STORE_FIFO_DEPTH + 1);
   localparam word_ctrl_t FILL_CTRL = `DQ_CTRL_FILL;
   localparam dram_word_t FILL_PAIR = {FILL_CTRL, word_data_t'(0), FILL_CTRL, word_data_t'(0)};

   store_state_t     state;
   word_data_t       hold_data;
   word_ctrl_t       hold_ctrl;
   logic             half_valid;    // Upper word waiting for its partner
   dram_word_t       pair;
   logic             pair_valid;
   logic             tail_end;      // Newest queued pair closes a packet
   logic [2:0]       blk_words;
   logic [2:0]       word_cnt;
   block_addr_t      wr_addr_plus_1;
   logic             ring_empty;
   logic             ring_full;
   logic             short_ok;
   logic             sf_wr_en;
   logic             sf_rd_en;
   logic             sf_empty;
   logic             sf_almost_full;
   dram_word_t       sf_dout;
   logic [CNT_W-1:0] sf_count;

   pkt_fifo #(.WIDTH(`DQ_DRAM_WIDTH), .DEPTH(`DQ_STORE_FIFO_DEPTH)) u_store_fifo (
      .clk(clk), .reset(reset), .din(pair), .wr_en(sf_wr_en), .rd_en(sf_rd_en),
      .dout(sf_dout), .full(), .empty(sf_empty), .almost_full(sf_almost_full),
      .count(sf_count)
   );

   ////////////////////////////////////////
   // Pairing

   always_ff @(posedge clk) begin
      if (reset) begin
         half_valid <= 1'b0;
         pair_valid <= 1'b0;
      end else begin
         pair_valid <= in_wr && (half_valid || in_ctrl == `DQ_CTRL_LAST);
         if (in_wr) half_valid <= !half_valid && in_ctrl != `DQ_CTRL_LAST;
      end
   end

   always_ff @(posedge clk) begin
      if (in_wr && !half_valid) begin
         hold_data <= in_data;
         hold_ctrl <= in_ctrl;
      end
      if (in_wr) begin
         if (half_valid) pair <= {hold_ctrl, hold_data, in_ctrl, in_data};
         else pair <= {in_ctrl, in_data, FILL_PAIR[`DQ_DRAM_WIDTH/2-1:0]};  // Lone last word
      end
   end

   ////////////////////////////////////////
   // Routing and ring status

   assign wr_addr_plus_1 = (oq_wr_addr >= block_addr_hi) ? block_addr_lo : oq_wr_addr + 1'b1;
   assign ring_empty     = (oq_wr_addr == oq_rd_addr);
   assign ring_full      = (wr_addr_plus_1 == oq_rd_addr);

   // Bypass DRAM only when nothing older is still queued
   assign short_ok = remove_pkt_idle && ring_empty && sf_empty && !fifo_almost_full_out &&
                     state == ST_IDLE;

   assign fifo_din_in   = pair;
   assign fifo_wr_en_in = pair_valid && short_ok;
   assign sf_wr_en      = pair_valid && !short_ok;
   assign in_rdy        = !sf_almost_full && !(ring_full && sf_count >= `DQ_BLOCK_WORDS);

   always_ff @(posedge clk) begin
      if (reset) begin
         tail_end <= 1'b0;
      end else if (sf_wr_en) begin
         tail_end <= pair[`DQ_DRAM_WIDTH-1 -: `DQ_CTRL_WIDTH] == `DQ_CTRL_LAST ||
                     pair[`DQ_DATA_WIDTH +: `DQ_CTRL_WIDTH] == `DQ_CTRL_LAST;
      end
   end

   ////////////////////////////////////////
   // Block writer

   assign dram_wr_req  = (state == ST_WR_REQ);
   assign dram_wr_en   = (state == ST_WRITE);
   assign sf_rd_en     = dram_wr_en && (word_cnt < blk_words);
   assign dram_wr_data = sf_rd_en ? sf_dout : FILL_PAIR;  // Pad short blocks
   assign dram_wr_ptr  = dram_addr_t'(oq_wr_addr * `DQ_BLOCK_WORDS);

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ST_IDLE;
         oq_wr_addr <= '0;
         blk_words  <= '0;
         word_cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (!sf_empty && (sf_count >= `DQ_BLOCK_WORDS || tail_end) && !ring_full) begin
                  state     <= ST_WR_REQ;
                  blk_words <= (sf_count >= `DQ_BLOCK_WORDS) ? 3'(`DQ_BLOCK_WORDS) : sf_count[2:0];
               end
            end
            ST_WR_REQ: begin
               word_cnt <= '0;
               if (dram_wr_ack) state <= ST_WRITE;
            end
            ST_WRITE: begin
               word_cnt <= word_cnt + 1'b1;
               if (dram_wr_done) state <= ST_WR_DONE;
            end
            default: begin  // ST_WR_DONE
               state      <= ST_IDLE;
               oq_wr_addr <= wr_addr_plus_1;
            end
         endcase
         if (ctrl[`DQ_CTRL_BIT_INIT]) oq_wr_addr <= block_addr_lo;
      end
   end

   // Reader must have freed the slot before any word lands
   a_no_write_full: assert property (@(posedge clk) disable iff (reset)
      dram_wr_en |-> !ring_full);

endmodule

// File: hdl/remove_pkt_dram.sv
/* Read side of the queue: block fetch from the DRAM ring,
   read FIFO and pair unpacking to the output port */
`include "dram_queue_consts.svh"

module remove_pkt_dram (
   input  logic                        clk,
   input  logic                        reset,
   output dram_queue_pkg::block_addr_t oq_rd_addr,
   input  dram_queue_pkg::block_addr_t oq_wr_addr,
   output logic                        dram_rd_req,
   output dram_queue_pkg::dram_addr_t  dram_rd_ptr,
   output logic                        dram_rd_en,
   input  dram_queue_pkg::dram_word_t  dram_rd_data,
   input  logic                        dram_rd_ack,
   input  logic                        dram_rd_rdy,
   input  logic                        dram_rd_done,
   output dram_queue_pkg::word_data_t  out_data,
   output dram_queue_pkg::word_ctrl_t  out_ctrl,
   output logic                        out_wr,
   input  logic                        out_rdy,
   input  dram_queue_pkg::dram_word_t  fifo_din_in,
   input  logic                        fifo_wr_en_in,
   output logic                        fifo_almost_full_out,
   output logic                        remove_pkt_idle,
   output logic                        output_words,
   output logic                        dram_rd_words,
   output logic                        pkts_removed,
   output dram_queue_pkg::block_addr_t rd_addr,
   input  dram_queue_pkg::block_addr_t block_addr_hi,
   input  dram_queue_pkg::block_addr_t block_addr_lo,
   input  dram_queue_pkg::queue_ctrl_t ctrl
);
   import dram_queue_pkg::*;

   localparam int CNT_W = $clog2(`DQ_REMOVE_FIFO_DEPTH + 1);

   remove_state_t    state;
   block_addr_t      rd_addr_plus_1;
   logic             half_sel;     // Lower word of the head pair is next
   logic             word_pop;
   logic             fifo_wr_en;
   logic             fifo_rd_en;
   logic             fifo_empty;
   logic             fifo_rdy;
   logic             dram_rdy;
   dram_word_t       fifo_din;
   dram_word_t       fifo_dout;
   logic [CNT_W-1:0] fifo_count;

   pkt_fifo #(.WIDTH(`DQ_DRAM_WIDTH), .DEPTH(`DQ_REMOVE_FIFO_DEPTH)) u_remove_fifo (
      .clk(clk), .reset(reset), .din(fifo_din), .wr_en(fifo_wr_en), .rd_en(fifo_rd_en),
      .dout(fifo_dout), .full(), .empty(fifo_empty), .almost_full(fifo_almost_full_out),
      .count(fifo_count)
   );

   ////////////////////////////////////////
   // Output side

   assign {out_ctrl, out_data} = half_sel ? fifo_dout[`DQ_DRAM_WIDTH/2-1:0]
                                          : fifo_dout[`DQ_DRAM_WIDTH-1:`DQ_DRAM_WIDTH/2];

   assign word_pop     = out_rdy && !fifo_empty && !ctrl[`DQ_CTRL_BIT_DISABLE];
   assign fifo_rd_en   = word_pop && half_sel;                  // Pair done after lower word
   assign out_wr       = word_pop && out_ctrl != `DQ_CTRL_FILL;  // Filler words vanish here
   assign output_words = word_pop;
   assign pkts_removed = out_wr && out_ctrl == `DQ_CTRL_LAST;
   assign rd_addr      = oq_rd_addr;

   ////////////////////////////////////////
   // Block fetch

   assign rd_addr_plus_1 = (oq_rd_addr >= block_addr_hi) ? block_addr_lo : oq_rd_addr + 1'b1;
   assign dram_rdy       = (oq_rd_addr != oq_wr_addr);
   assign fifo_rdy       = (fifo_count <= `DQ_REMOVE_FIFO_DEPTH - `DQ_BLOCK_WORDS);

   assign dram_rd_req     = (state == ST_RD_REQ);
   assign dram_rd_ptr     = dram_addr_t'(oq_rd_addr * `DQ_BLOCK_WORDS);
   assign dram_rd_en      = (state == ST_READ) && dram_rd_rdy;
   assign dram_rd_words   = dram_rd_en;
   assign remove_pkt_idle = (state == ST_WAIT_FOR_DATA);

   // Short path owns the FIFO write port while idle
   assign fifo_wr_en = remove_pkt_idle ? fifo_wr_en_in : dram_rd_en;
   assign fifo_din   = remove_pkt_idle ? fifo_din_in : dram_rd_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ST_WAIT_FOR_DATA;
         oq_rd_addr <= '0;
         half_sel   <= 1'b0;
      end else begin
         if (word_pop) half_sel <= !half_sel;
         case (state)
            ST_WAIT_FOR_DATA: if (fifo_rdy && dram_rdy) state <= ST_RD_REQ;
            ST_RD_REQ:        if (dram_rd_ack) state <= ST_READ;
            ST_READ:          if (dram_rd_done) state <= ST_RD_DONE;
            default: begin    // ST_RD_DONE
               state      <= ST_WAIT_FOR_DATA;
               oq_rd_addr <= rd_addr_plus_1;
            end
         endcase
         if (ctrl[`DQ_CTRL_BIT_INIT]) oq_rd_addr <= block_addr_lo;
      end
   end

   // DRAM only returns data while this side is collecting it
   a_rd_in_read: assert property (@(posedge clk) disable iff (reset)
      dram_rd_rdy |-> state == ST_READ);

endmodule

// File: hdl/dram_arbiter.sv
/* Round-robin sharing of the single DRAM port between block writer and reader */
module dram_arbiter (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       wr_req,
   output logic                       wr_ack,
   output logic                       wr_done,
   input  dram_queue_pkg::dram_addr_t wr_ptr,
   input  logic                       wr_en,
   input  dram_queue_pkg::dram_word_t wr_data,
   input  logic                       rd_req,
   output logic                       rd_ack,
   output logic                       rd_done,
   input  dram_queue_pkg::dram_addr_t rd_ptr,
   input  logic                       rd_en,
   output logic                       mem_req,
   output logic                       mem_dir,     // 1 for a block read
   output dram_queue_pkg::dram_addr_t mem_ptr,
   output logic                       mem_wr_en,
   output dram_queue_pkg::dram_word_t mem_wr_data,
   input  logic                       mem_ack,
   input  logic                       mem_done
);
   import dram_queue_pkg::*;

   logic grant_wr;
   logic grant_rd;
   logic prio_rd;   // Reader wins a tie

   always_ff @(posedge clk) begin
      if (reset) begin
         grant_wr <= 1'b0;
         grant_rd <= 1'b0;
         prio_rd  <= 1'b0;
      end else if (mem_done) begin
         grant_wr <= 1'b0;
         grant_rd <= 1'b0;
         prio_rd  <= grant_wr;  // Other client next time
      end else if (!grant_wr && !grant_rd) begin
         if (wr_req && (!rd_req || !prio_rd)) grant_wr <= 1'b1;
         else if (rd_req) grant_rd <= 1'b1;
      end
   end

   assign mem_req     = (grant_wr && wr_req) || (grant_rd && rd_req);
   assign mem_dir     = grant_rd;
   assign mem_ptr     = grant_rd ? rd_ptr : wr_ptr;
   assign mem_wr_en   = grant_wr && wr_en;
   assign mem_wr_data = grant_wr ? wr_data : '0;

   assign wr_ack  = grant_wr && mem_ack;
   assign rd_ack  = grant_rd && mem_ack;
   assign wr_done = grant_wr && mem_done;
   assign rd_done = grant_rd && mem_done;

   // Each client strobes data only while it owns the port
   a_one_grant: assert property (@(posedge clk) disable iff (reset)
      (!rd_en || grant_rd) && (!wr_en || grant_wr));

endmodule

// File: hdl/dram_block_mem.sv
/* Behavioural DRAM with four-word block writes and reads after an ack */
`include "dram_queue_consts.svh"

module dram_block_mem (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       req,
   input  logic                       dir,
   input  dram_queue_pkg::dram_addr_t ptr,
   input  logic                       wr_en,
   input  dram_queue_pkg::dram_word_t wr_data,
   output logic                       ack,
   output dram_queue_pkg::dram_word_t rd_data,
   output logic                       rd_rdy,
   output logic                       done
);
   import dram_queue_pkg::*;

   dram_word_t mem [2**`DQ_DRAM_ADDR_WIDTH];
   logic       busy;
   logic       rd_dir;
   dram_addr_t base;
   logic [$clog2(`DQ_BLOCK_WORDS)-1:0] cnt;   // Word within the block
   dram_addr_t addr;

   assign addr    = base + dram_addr_t'(cnt);
   assign ack     = req && !busy;
   assign rd_rdy  = busy && rd_dir;
   assign rd_data = mem[addr];
   assign done    = busy && (rd_dir || wr_en) && cnt == `DQ_BLOCK_WORDS - 1;

   always_ff @(posedge clk) begin
      if (ack) base <= ptr;
      if (busy && !rd_dir && wr_en) mem[addr] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy   <= 1'b0;
         rd_dir <= 1'b0;
         cnt    <= '0;
      end else if (ack) begin
         busy   <= 1'b1;
         rd_dir <= dir;
         cnt    <= '0;
      end else if (busy && (rd_dir || wr_en)) begin
         cnt <= cnt + 1'b1;
         if (done) busy <= 1'b0;
      end
   end

endmodule

// File: hdl/dram_queue.sv
/* Top level of the DRAM-backed output queue */
module dram_queue (
   input  logic                        clk,
   input  logic                        reset,
   input  dram_queue_pkg::word_data_t  in_data,
   input  dram_queue_pkg::word_ctrl_t  in_ctrl,
   input  logic                        in_wr,
   output logic                        in_rdy,
   output dram_queue_pkg::word_data_t  out_data,
   output dram_queue_pkg::word_ctrl_t  out_ctrl,
   output logic                        out_wr,
   input  logic                        out_rdy,
   input  dram_queue_pkg::queue_ctrl_t ctrl,
   input  dram_queue_pkg::block_addr_t block_addr_hi,
   input  dram_queue_pkg::block_addr_t block_addr_lo,
   output dram_queue_pkg::block_addr_t rd_addr,
   output logic                        output_words,
   output logic                        dram_rd_words,
   output logic                        pkts_removed
);
   import dram_queue_pkg::*;

   block_addr_t oq_wr_addr, oq_rd_addr;
   dram_word_t  fifo_din_in, dram_wr_data, dram_rd_data, mem_wr_data;
   dram_addr_t  dram_wr_ptr, dram_rd_ptr, mem_ptr;
   logic        fifo_wr_en_in, fifo_almost_full_out, remove_pkt_idle;
   logic        dram_wr_req, dram_wr_en, dram_wr_ack, dram_wr_done;
   logic        dram_rd_req, dram_rd_en, dram_rd_ack, dram_rd_rdy, dram_rd_done;
   logic        mem_req, mem_dir, mem_wr_en, mem_ack, mem_done;

   store_pkt_dram  u_store (.*);
   remove_pkt_dram u_remove (.*);

   dram_arbiter u_arbiter (
      .clk(clk), .reset(reset),
      .wr_req(dram_wr_req), .wr_ack(dram_wr_ack), .wr_done(dram_wr_done),
      .wr_ptr(dram_wr_ptr), .wr_en(dram_wr_en), .wr_data(dram_wr_data),
      .rd_req(dram_rd_req), .rd_ack(dram_rd_ack), .rd_done(dram_rd_done),
      .rd_ptr(dram_rd_ptr), .rd_en(dram_rd_en),
      .mem_req(mem_req), .mem_dir(mem_dir), .mem_ptr(mem_ptr), .mem_wr_en(mem_wr_en),
      .mem_wr_data(mem_wr_data), .mem_ack(mem_ack), .mem_done(mem_done)
   );

   // Read data and strobe go straight to the reader
   dram_block_mem u_dram (
      .clk(clk), .reset(reset), .req(mem_req), .dir(mem_dir), .ptr(mem_ptr),
      .wr_en(mem_wr_en), .wr_data(mem_wr_data), .ack(mem_ack),
      .rd_data(dram_rd_data), .rd_rdy(dram_rd_rdy), .done(mem_done)
   );

endmodule

// File: verif/tb_dram_queue.sv
/* Directed testbench for the DRAM output queue: clock, reset, queue model,
   test tasks, compare tasks and watchdog */
`include "dram_queue_consts.svh"

module tb_dram_queue;
   import dram_queue_pkg::*;

   localparam int CLK_PERIOD     = 8;
   localparam int MAX_TEST_WORDS = 1810;  // Upper bound over all five tests

   logic        clk;
   logic        reset;
   word_data_t  in_data;
   word_ctrl_t  in_ctrl;
   logic        in_wr;
   logic        in_rdy;
   word_data_t  out_data;
   word_ctrl_t  out_ctrl;
   logic        out_wr;
   logic        out_rdy;
   queue_ctrl_t ctrl;
   block_addr_t block_addr_hi;
   block_addr_t block_addr_lo;
   block_addr_t rd_addr;
   logic        output_words;
   logic        dram_rd_words;
   logic        pkts_removed;

   word_data_t  exp_data[$];   // Model queue, one entry per sent word
   word_ctrl_t  exp_ctrl[$];
   string       cur_test;
   int          errors, checks, tests_run, tests_failed;
   int          out_cnt, ow_cnt, drw_cnt, pkt_cnt;
   int          pkt_seq, words_sent;
   bit          range_watch, stalled, feed_done;

   dram_queue u_dram_queue (
      .clk(clk), .reset(reset),
      .in_data(in_data), .in_ctrl(in_ctrl), .in_wr(in_wr), .in_rdy(in_rdy),
      .out_data(out_data), .out_ctrl(out_ctrl), .out_wr(out_wr), .out_rdy(out_rdy),
      .ctrl(ctrl), .block_addr_hi(block_addr_hi), .block_addr_lo(block_addr_lo),
      .rd_addr(rd_addr), .output_words(output_words), .dram_rd_words(dram_rd_words),
      .pkts_removed(pkts_removed)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(200 * MAX_TEST_WORDS * CLK_PERIOD);
      $display("watchdog expired in test %s, the queue stopped moving", cur_test);
      $display("TESTBENCH FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // Compare tasks

   task automatic check_word(input word_data_t exp_d, input word_ctrl_t exp_c,
                             input word_data_t act_d, input word_ctrl_t act_c);
      checks++;
      if (exp_d !== act_d || exp_c !== act_c) begin
         $display("error %s: expected %h/%h actual %h/%h", cur_test, exp_c, exp_d, act_c, act_d);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input int exp_n, input int act_n);
      checks++;
      if (exp_n != act_n) begin
         $display("error %s: %s expected %0d actual %0d", cur_test, what, exp_n, act_n);
         errors++;
      end
   endtask

   task automatic check_addr(input string what, input block_addr_t exp_a,
                             input block_addr_t act_a);
      checks++;
      if (exp_a !== act_a) begin
         $display("error %s: %s expected %0d actual %0d", cur_test, what, exp_a, act_a);
         errors++;
      end
   endtask

   // Output monitor and event counters
   always @(posedge clk) begin : monitor
      word_data_t d;
      word_ctrl_t c;
      if (!reset) begin
         if (output_words) ow_cnt++;
         if (dram_rd_words) drw_cnt++;
         if (pkts_removed) pkt_cnt++;
         if (out_wr) begin
            out_cnt++;
            if (exp_data.size() == 0) begin
               $display("unexpected word %h on the output in test %s", out_data, cur_test);
               errors++;
            end else begin
               d = exp_data.pop_front();
               c = exp_ctrl.pop_front();
               check_word(d, c, out_data, out_ctrl);
            end
         end
         if (range_watch && (rd_addr < block_addr_lo || rd_addr > block_addr_hi)) begin
            $display("rd_addr %0d left the block range in test %s", rd_addr, cur_test);
            errors++;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus helpers

   task automatic start_test(input string name);
      cur_test   = name;
      tests_run++;
      out_cnt    = 0;
      ow_cnt     = 0;
      drw_cnt    = 0;
      pkt_cnt    = 0;
      words_sent = 0;
   endtask

   task automatic finish_test(input int err_base);
      if (errors == err_base) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: %0d errors", cur_test, errors - err_base);
         tests_failed++;
      end
   endtask

   task automatic send_packet(input int len);
      int         i;
      word_data_t d;
      word_ctrl_t c;
      i = 0;
      while (i < len) begin
         @(posedge clk);
         if (in_rdy) begin
            d = {pkt_seq[15:0], 16'(i), $urandom};
            c = (i == len - 1) ? `DQ_CTRL_LAST : 8'h00;
            in_data <= d;
            in_ctrl <= c;
            in_wr   <= 1'b1;
            exp_data.push_back(d);
            exp_ctrl.push_back(c);
            i++;
         end else begin
            in_wr <= 1'b0;
         end
      end
      @(posedge clk);
      in_wr <= 1'b0;
      pkt_seq++;
      words_sent += len;
   endtask

   // Waits until every modelled word came out, then lets fillers pop
   task automatic wait_drained();
      int n;
      int limit;
      n     = 0;
      limit = 200 * exp_data.size() + 100;
      while (exp_data.size() > 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (exp_data.size() > 0) begin
         $display("%0d words never left the queue in test %s", exp_data.size(), cur_test);
         errors++;
      end
      repeat (16) @(posedge clk);
   endtask

   // Packets with out_rdy low until in_rdy falls, then out_rdy goes high
   task automatic fill_until_stall(input int max_pkts);
      int p;
      stalled   = 0;
      feed_done = 0;
      out_rdy  <= 1'b0;
      fork
         begin
            for (p = 0; p < max_pkts && !stalled; p++) send_packet(1 + $urandom % 16);
            feed_done = 1;
         end
         begin
            while (!stalled && !feed_done) begin
               @(posedge clk);
               if (!in_rdy) stalled = 1;
            end
            repeat (20) @(posedge clk);
            out_rdy <= 1'b1;
         end
      join
      if (!stalled) begin
         $display("in_rdy never fell during the burst in test %s", cur_test);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // Tests

   task automatic test_short_path();
      int base;
      base = errors;
      start_test("short_path");
      out_rdy <= 1'b1;
      send_packet(5);
      wait_drained();
      check_count("words out", 5, out_cnt);
      check_count("pkts_removed", 1, pkt_cnt);
      check_count("dram_rd_words", 0, drw_cnt);
      finish_test(base);
   endtask

   task automatic test_dram_path();
      int base;
      int pkts;
      base = errors;
      start_test("dram_path");
      pkts = pkt_seq;
      fill_until_stall(60);
      wait_drained();
      check_count("pkts_removed", pkt_seq - pkts, pkt_cnt);
      check_count("dram_rd_words mod 4", 0, drw_cnt % 4);
      if (drw_cnt == 0) begin
         $display("no block was read from DRAM in test %s", cur_test);
         errors++;
      end
      finish_test(base);
   endtask

   task automatic test_disable_send();
      int base;
      int i;
      base = errors;
      start_test("disable_send");
      out_rdy <= 1'b1;
      ctrl    <= 2'b10;
      send_packet(6);
      for (i = 0; i < 50; i++) begin
         @(posedge clk);
         if (out_wr) begin
            $display("out_wr rose while sending was disabled in test %s", cur_test);
            errors++;
         end
      end
      ctrl <= 2'b00;
      wait_drained();
      check_count("words out", 6, out_cnt);
      finish_test(base);
   endtask

   task automatic test_event_pulses();
      int base;
      int p;
      base      = errors;
      start_test("event_pulses");
      feed_done = 0;
      fork
         begin
            for (p = 0; p < 12; p++) send_packet(1 + $urandom % 16);
            feed_done = 1;
         end
         begin
            while (!feed_done) begin
               @(posedge clk);
               out_rdy <= $urandom % 2;  // Random back-pressure
            end
         end
      join
      out_rdy <= 1'b1;
      wait_drained();
      check_count("pkts_removed", 12, pkt_cnt);
      check_count("words out", words_sent, out_cnt);
      if (ow_cnt < out_cnt) begin
         $display("output_words pulsed %0d times for %0d words", ow_cnt, out_cnt);
         errors++;
      end
      finish_test(base);
   endtask

   task automatic test_block_range();
      int base;
      base = errors;
      start_test("block_range");
      @(posedge clk);
      block_addr_lo <= 3'd2;
      block_addr_hi <= 3'd5;
      ctrl          <= 2'b01;
      @(posedge clk);
      ctrl <= 2'b00;
      @(posedge clk);
      check_addr("rd_addr after init", 3'd2, rd_addr);
      range_watch = 1;
      fill_until_stall(40);
      wait_drained();
      range_watch = 0;
      check_count("words out", words_sent, out_cnt);
      finish_test(base);
   endtask

   initial begin
      reset         = 1'b1;
      in_data       = '0;
      in_ctrl       = '0;
      in_wr         = 1'b0;
      out_rdy       = 1'b0;
      ctrl          = '0;
      block_addr_lo = 3'd0;
      block_addr_hi = 3'd7;
      range_watch   = 0;
      cur_test      = "reset";
      void'($urandom(32'h5059));
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);

      test_short_path();
      test_dram_path();
      test_disable_send();
      test_event_pulses();
      test_block_range();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: dram_queue.f
+incdir+hdl
hdl/dram_queue_pkg.sv
hdl/pkt_fifo.sv
hdl/store_pkt_dram.sv
hdl/remove_pkt_dram.sv
hdl/dram_arbiter.sv
hdl/dram_block_mem.sv
hdl/dram_queue.sv
verif/tb_dram_queue.sv

// File: Makefile
# Verilator build and run for the DRAM output queue testbench
TOP = tb_dram_queue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f dram_queue.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
